// ==== tinker_macros.svh ====
`ifndef TINKER_MACROS_SVH
`define TINKER_MACROS_SVH

// instruction memory, 256 words of 32 bits
`define IMEM_AW 8

// data memory, 256 doublewords
`define DMEM_AW 8

// first fetch address after reset, byte address
`define RESET_PC 64'h2000

// field msb positions in the instruction word
// opcode 31:27, rd 26:22, rs 21:17, rt 16:12
`define OPC_MSB 31
`define RD_MSB 26
`define RS_MSB 21
`define RT_MSB 16

// literal sits in the low bits
`define LIT_MSB 11

`endif

// ==== tinker_pkg.sv ====
`include "tinker_macros.svh"

package tinker_pkg;

    // register and memory data
    typedef logic [63:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0] reg_idx_t;
    // signed literal, extended at use
    typedef logic [11:0] lit_t;

    // word index into instruction memory
    typedef logic [`IMEM_AW-1:0] imem_addr_t;
    // doubleword index into data memory
    typedef logic [`DMEM_AW-1:0] dmem_addr_t;

    // kept opcodes only
    // op_and with rd = 0 is also the pipeline bubble
    typedef enum logic [4:0] {
        op_and    = 5'b00000,
        op_or     = 5'b00001,
        op_xor    = 5'b00010,
        op_not    = 5'b00011,
        op_shftr  = 5'b00100,
        op_shftri = 5'b00101,
        op_shftl  = 5'b00110,
        op_shftli = 5'b00111,
        op_jump   = 5'b01000,
        op_brnz   = 5'b01011,
        op_halt   = 5'b01111,
        op_load   = 5'b10000,
        op_mov    = 5'b10001,
        op_movl   = 5'b10010,
        op_store  = 5'b10011,
        op_add    = 5'b11000,
        op_addi   = 5'b11001,
        op_sub    = 5'b11010,
        op_subi   = 5'b11011
    } opcode_e;

endpackage

// ==== tinker_ifs.sv ====
`timescale 1ns/1ps

// ID/EX register contents, decode to execute
interface issue_if import tinker_pkg::*; ();
    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    pc;
    // register file values read in decode
    word_t    a_val;
    // rt value or extended literal
    word_t    b_val;
    word_t    rd_val;
    lit_t     lit;
    logic     uses_rt;

    modport producer (
        output opcode, rd, rs, rt, pc, a_val, b_val, rd_val, lit, uses_rt
    );
    modport consumer (
        input opcode, rd, rs, rt, pc, a_val, b_val, rd_val, lit, uses_rt
    );
endinterface

// EX/MEM register contents, execute to memory stage
interface exmem_if import tinker_pkg::*; ();
    opcode_e    opcode;
    reg_idx_t   rd;
    word_t      alu_val;
    logic       reg_write;
    logic       mem_write;
    dmem_addr_t mem_addr;
    word_t      store_val;
    // taken jump or brnz
    logic       redirect;
    word_t      target;

    modport producer (
        output opcode, rd, alu_val, reg_write, mem_write, mem_addr, store_val,
               redirect, target
    );
    modport consumer (
        input opcode, rd, alu_val, reg_write, mem_write, mem_addr, store_val
    );
    // decode looks back for load-use and redirect
    modport monitor (
        input opcode, rd, redirect, target
    );
endinterface

// ==== fetch_decode.sv ====
`timescale 1ns/1ps
`include "tinker_macros.svh"

module fetch_decode import tinker_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  instr_t     prog_data,
    input  logic       wb_valid,
    input  reg_idx_t   wb_reg,
    input  word_t      wb_data,
    issue_if.producer  issue,
    exmem_if.monitor   exmem
);
    instr_t     imem [1 << `IMEM_AW];
    word_t      rf [1 << $bits(reg_idx_t)];

    word_t      pc;
    word_t      pc_off;
    imem_addr_t fetch_idx;
    // set once halt leaves decode
    logic       fetch_stop;

    instr_t     if_id_instr;
    word_t      if_id_pc;

    opcode_e    dec_opcode;
    reg_idx_t   dec_rd;
    reg_idx_t   dec_rs;
    reg_idx_t   dec_rt;
    lit_t       dec_lit;
    logic       dec_uses_rt;
    logic       dec_reads_rd;
    word_t      dec_a;
    word_t      dec_b;
    word_t      dec_rd_val;
    logic       load_use;

    // program load port, only live while reset is held
    always_ff @(posedge clk) begin
        if (reset && prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // byte pc to word index
    assign pc_off    = pc - `RESET_PC;
    assign fetch_idx = pc_off[`IMEM_AW+1:2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc          <= `RESET_PC;
            if_id_instr <= '0;
            fetch_stop  <= 1'b0;
        end else if (exmem.redirect) begin
            // wrong-path fetch dropped, restart at target
            pc          <= exmem.target;
            if_id_instr <= '0;
            fetch_stop  <= 1'b0;
        end else if (fetch_stop || dec_opcode == op_halt) begin
            if_id_instr <= '0;
            fetch_stop  <= 1'b1;
        end else if (!load_use) begin
            pc          <= pc + 64'd4;
            if_id_instr <= imem[fetch_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!load_use) begin
            if_id_pc <= pc;
        end
    end

    // field split
    assign dec_opcode = opcode_e'(if_id_instr[`OPC_MSB -: 5]);
    assign dec_rd     = if_id_instr[`RD_MSB -: $bits(reg_idx_t)];
    assign dec_rs     = if_id_instr[`RS_MSB -: $bits(reg_idx_t)];
    assign dec_rt     = if_id_instr[`RT_MSB -: $bits(reg_idx_t)];
    assign dec_lit    = if_id_instr[`LIT_MSB:0];

    // register-register forms take rt, the rest the literal
    assign dec_uses_rt = dec_opcode inside {op_add, op_sub, op_and, op_or, op_xor,
                                            op_shftr, op_shftl};
    // rd read as a source
    assign dec_reads_rd = dec_opcode inside {op_addi, op_subi, op_movl, op_store,
                                             op_jump, op_brnz};

    // r0 is zero, a write in the same cycle passes straight through
    function automatic word_t rf_read(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_valid && wb_reg == idx) begin
            return wb_data;
        end
        return rf[idx];
    endfunction

    always_comb begin
        dec_a      = rf_read(dec_rs);
        dec_rd_val = rf_read(dec_rd);
        dec_b      = dec_uses_rt ? rf_read(dec_rt) : word_t'(signed'(dec_lit));
    end

    // wb_valid is never set for r0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < (1 << $bits(reg_idx_t)); i++) begin
                rf[i] <= '0;
            end
        end else if (wb_valid) begin
            rf[wb_reg] <= wb_data;
        end
    end

    // load in EX/MEM feeding the instruction in decode
    assign load_use = exmem.opcode == op_load && exmem.rd != '0 &&
                      (exmem.rd == dec_rs ||
                       (dec_uses_rt && exmem.rd == dec_rt) ||
                       (dec_reads_rd && exmem.rd == dec_rd));

    // ID/EX control, bubble on flush or stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue.opcode  <= op_and;
            issue.rd      <= '0;
            issue.rs      <= '0;
            issue.rt      <= '0;
            issue.uses_rt <= 1'b0;
        end else if (exmem.redirect || load_use) begin
            issue.opcode  <= op_and;
            issue.rd      <= '0;
            issue.rs      <= '0;
            issue.rt      <= '0;
            issue.uses_rt <= 1'b0;
        end else begin
            issue.opcode  <= dec_opcode;
            issue.rd      <= dec_rd;
            issue.rs      <= dec_rs;
            issue.rt      <= dec_rt;
            issue.uses_rt <= dec_uses_rt;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        issue.pc     <= if_id_pc;
        issue.a_val  <= dec_a;
        issue.b_val  <= dec_b;
        issue.rd_val <= dec_rd_val;
        issue.lit    <= dec_lit;
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps
`include "tinker_macros.svh"

module execute_stage import tinker_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      wb_valid,
    input  reg_idx_t  wb_reg,
    input  word_t     wb_data,
    input  word_t     load_data,
    issue_if.consumer issue,
    exmem_if.producer exmem
);
    word_t ex_fwd_val;
    word_t fwd_rs;
    word_t fwd_rt;
    word_t fwd_rd;
    word_t op_a;
    word_t op_b;
    word_t lit_ext;
    word_t ex_alu;
    word_t ex_addr;
    word_t ex_target;
    logic  ex_reg_write;
    logic  ex_mem_write;
    logic  ex_redirect;

    // a load in EX/MEM forwards its memory data
    assign ex_fwd_val = (exmem.opcode == op_load) ? load_data : exmem.alu_val;

    // newest producer wins, EX/MEM before MEM/WB
    function automatic word_t fwd(input reg_idx_t idx, input word_t issued);
        if (idx != '0 && exmem.reg_write && exmem.rd == idx) begin
            return ex_fwd_val;
        end
        if (wb_valid && wb_reg == idx) begin
            return wb_data;
        end
        return issued;
    endfunction

    always_comb begin
        fwd_rs = fwd(issue.rs, issue.a_val);
        fwd_rt = fwd(issue.rt, issue.b_val);
        fwd_rd = fwd(issue.rd, issue.rd_val);
    end

    // addi and subi accumulate into rd
    assign op_a    = (issue.opcode inside {op_addi, op_subi}) ? fwd_rd : fwd_rs;
    assign op_b    = issue.uses_rt ? fwd_rt : issue.b_val;
    assign lit_ext = word_t'(signed'(issue.lit));

    always_comb begin
        ex_alu       = '0;
        ex_reg_write = 1'b1;
        ex_mem_write = 1'b0;
        ex_redirect  = 1'b0;
        // load address by default
        ex_addr      = fwd_rs + lit_ext;
        ex_target    = issue.pc + 64'd4;
        case (issue.opcode)
            op_add, op_addi:     ex_alu = op_a + op_b;
            op_sub, op_subi:     ex_alu = op_a - op_b;
            op_and:              ex_alu = op_a & op_b;
            op_or:               ex_alu = op_a | op_b;
            op_xor:              ex_alu = op_a ^ op_b;
            op_not:              ex_alu = ~op_a;
            op_shftr, op_shftri: ex_alu = op_a >> op_b;
            op_shftl, op_shftli: ex_alu = op_a << op_b;
            op_mov:              ex_alu = op_a;
            // only the low 12 bits of rd change
            op_movl:             ex_alu = {fwd_rd[63:12], issue.lit};
            op_load:             ex_alu = ex_addr;
            op_store: begin
                ex_reg_write = 1'b0;
                ex_mem_write = 1'b1;
                ex_addr      = fwd_rd + lit_ext;
            end
            op_jump: begin
                ex_reg_write = 1'b0;
                ex_redirect  = 1'b1;
                ex_target    = fwd_rd;
            end
            op_brnz: begin
                ex_reg_write = 1'b0;
                if (fwd_rs != '0) begin
                    ex_redirect = 1'b1;
                    ex_target   = fwd_rd;
                end
            end
            // halt and unused codes write nothing
            default:             ex_reg_write = 1'b0;
        endcase
    end

    // EX/MEM control
    // the slot behind a taken branch is squashed here
    always_ff @(posedge clk or posedge reset) begin
        if (reset || exmem.redirect) begin
            exmem.opcode    <= op_and;
            exmem.rd        <= '0;
            exmem.reg_write <= 1'b0;
            exmem.mem_write <= 1'b0;
            exmem.redirect  <= 1'b0;
        end else begin
            exmem.opcode    <= issue.opcode;
            exmem.rd        <= issue.rd;
            exmem.reg_write <= ex_reg_write;
            exmem.mem_write <= ex_mem_write;
            exmem.redirect  <= ex_redirect;
        end
    end

    // EX/MEM payload, doubleword index for memory
    always_ff @(posedge clk) begin
        exmem.alu_val   <= ex_alu;
        exmem.mem_addr  <= ex_addr[`DMEM_AW+2:3];
        exmem.store_val <= fwd_rs;
        exmem.target    <= ex_target;
    end

endmodule

// ==== mem_writeback.sv ====
`timescale 1ns/1ps
`include "tinker_macros.svh"

module mem_writeback import tinker_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    exmem_if.consumer exmem,
    output word_t     load_data,
    output logic      wb_valid,
    output reg_idx_t  wb_reg,
    output word_t     wb_data,
    output logic      hlt
);
    word_t dmem [1 << `DMEM_AW];
    // halt sitting in MEM/WB
    logic  memwb_halt;

    // asynchronous read, also feeds EX forwarding
    assign load_data = dmem[exmem.mem_addr];

    always_ff @(posedge clk) begin
        if (exmem.mem_write) begin
            dmem[exmem.mem_addr] <= exmem.store_val;
        end
    end

    // MEM/WB control
    // r0 targets and bubbles never retire a write
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid   <= 1'b0;
            memwb_halt <= 1'b0;
        end else begin
            wb_valid   <= exmem.reg_write && exmem.rd != '0;
            memwb_halt <= exmem.opcode == op_halt;
        end
    end

    // MEM/WB payload, load data or alu result
    always_ff @(posedge clk) begin
        wb_reg  <= exmem.rd;
        wb_data <= (exmem.opcode == op_load) ? load_data : exmem.alu_val;
    end

    // sticky until reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hlt <= 1'b0;
        end else if (memwb_halt) begin
            hlt <= 1'b1;
        end
    end

endmodule

// ==== tinker_core.sv ====
`timescale 1ns/1ps

module tinker_core import tinker_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  instr_t     prog_data,
    output logic       wb_valid,
    output reg_idx_t   wb_reg,
    output word_t      wb_data,
    output logic       hlt
);
    // memory read data into execute forwarding
    word_t load_data;

    // ID/EX and EX/MEM registers
    issue_if issue_bus ();
    exmem_if exmem_bus ();

    fetch_decode i_fetch_decode (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .issue     (issue_bus.producer),
        .exmem     (exmem_bus.monitor)
    );

    execute_stage i_execute_stage (
        .clk       (clk),
        .reset     (reset),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .load_data (load_data),
        .issue     (issue_bus.consumer),
        .exmem     (exmem_bus.producer)
    );

    // write-back also drives the core outputs
    mem_writeback i_mem_writeback (
        .clk       (clk),
        .reset     (reset),
        .exmem     (exmem_bus.consumer),
        .load_data (load_data),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .hlt       (hlt)
    );

endmodule

// ==== tinker_assert.sv ====
`timescale 1ns/1ps

module tinker_assert import tinker_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     wb_valid,
    input reg_idx_t wb_reg,
    input word_t    wb_data,
    input logic     hlt
);
    // edges since reset release
    // saturates at 4
    logic [2:0] since_reset;
    // number of failed assertions
    int         fail_count = 0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            since_reset <= '0;
        end else if (since_reset != 3'd4) begin
            since_reset <= since_reset + 3'd1;
        end
    end

    // nothing retires before fetch, decode, execute and memory have passed
    a_quiet_start: assert property (@(posedge clk) since_reset < 3'd4 |-> !wb_valid && !hlt)
        else begin
            fail_count++;
            $error("write-back or halt seen before the first instruction could retire");
        end

    // halt is sticky
    a_hlt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
        else begin
            fail_count++;
            $error("hlt dropped without a reset");
        end

    a_no_wb_after_hlt: assert property (@(posedge clk) disable iff (reset) hlt |-> !wb_valid)
        else begin
            fail_count++;
            $error("register write-back after the core halted");
        end

    // r0 is never a write target
    a_wb_reg_nonzero: assert property (@(posedge clk) disable iff (reset)
                                       wb_valid |-> wb_reg != '0)
        else begin
            fail_count++;
            $error("write-back aimed at r0");
        end

    a_wb_data_known: assert property (@(posedge clk) disable iff (reset)
                                      wb_valid |-> !$isunknown(wb_data))
        else begin
            fail_count++;
            $error("write-back data holds unknown bits");
        end

endmodule

bind tinker_core tinker_assert i_tinker_assert (
    .clk      (clk),
    .reset    (reset),
    .wb_valid (wb_valid),
    .wb_reg   (wb_reg),
    .wb_data  (wb_data),
    .hlt      (hlt)
);

// ==== tinker_tb.sv ====
`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_tb import tinker_pkg::*; ();
    logic       clk = 1'b0;
    logic       reset;
    logic       prog_we;
    imem_addr_t prog_addr;
    instr_t     prog_data;
    logic       wb_valid;
    reg_idx_t   wb_reg;
    word_t      wb_data;
    logic       hlt;

    // program image and architectural reference state
    instr_t   prog [$];
    word_t    model_rf [32];
    word_t    model_mem [1 << `DMEM_AW];
    reg_idx_t exp_reg [$];
    word_t    exp_val [$];
    // targets of instructions in a branch shadow or past halt
    logic     shadow_reg [32];
    int       prog_len;
    int       errors;

    tinker_core i_tinker_core (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .hlt       (hlt)
    );

    always #5 clk = ~clk;

    // byte address to doubleword index
    function automatic dmem_addr_t dword_index(input word_t byte_addr);
        return byte_addr[`DMEM_AW+2:3];
    endfunction

    // low 12 bits of the pc some slots past the current program end
    function automatic lit_t pc_ahead(input int slots);
        word_t pc;
        pc = `RESET_PC + 64'(4 * (prog.size() + slots));
        return pc[11:0];
    endfunction

    function automatic lit_t rnd_lit();
        return lit_t'($urandom);
    endfunction

    // append one instruction and retire it in the model when on the taken path
    task automatic put(input opcode_e op, input reg_idx_t rd, input reg_idx_t rs,
                       input reg_idx_t rt, input lit_t lit, input bit runs);
        word_t vs;
        word_t vt;
        word_t vd;
        word_t imm;
        word_t res;
        bit    writes;
        prog.push_back({op, rd, rs, rt, lit});
        if (!runs) begin
            shadow_reg[rd] = 1'b1;
            return;
        end
        vs     = model_rf[rs];
        vt     = model_rf[rt];
        vd     = model_rf[rd];
        imm    = {{52{lit[11]}}, lit};
        res    = '0;
        writes = 1'b1;
        case (op)
            op_add:    res = vs + vt;
            op_addi:   res = vd + imm;
            op_sub:    res = vs - vt;
            op_subi:   res = vd - imm;
            op_and:    res = vs & vt;
            op_or:     res = vs | vt;
            op_xor:    res = vs ^ vt;
            op_not:    res = ~vs;
            op_shftr:  res = vs >> vt;
            op_shftri: res = vs >> imm;
            op_shftl:  res = vs << vt;
            op_shftli: res = vs << imm;
            op_mov:    res = vs;
            op_movl:   res = {vd[63:12], lit};
            op_load:   res = model_mem[dword_index(vs + imm)];
            op_store: begin
                model_mem[dword_index(vd + imm)] = vs;
                writes = 1'b0;
            end
            // branches and halt leave registers alone
            default:   writes = 1'b0;
        endcase
        if (writes && rd != '0) begin
            model_rf[rd] = res;
            exp_reg.push_back(rd);
            exp_val.push_back(res);
        end
    endtask

    task automatic build_program();
        // dependent chain where every result feeds the next
        put(op_addi,   5'd1,  5'd0,  5'd0,  rnd_lit(), 1'b1);
        put(op_addi,   5'd2,  5'd0,  5'd0,  rnd_lit(), 1'b1);
        put(op_add,    5'd3,  5'd1,  5'd2,  12'd0,     1'b1);
        put(op_sub,    5'd4,  5'd3,  5'd1,  12'd0,     1'b1);
        put(op_subi,   5'd4,  5'd0,  5'd0,  rnd_lit(), 1'b1);
        put(op_and,    5'd5,  5'd4,  5'd3,  12'd0,     1'b1);
        put(op_or,     5'd6,  5'd5,  5'd4,  12'd0,     1'b1);
        put(op_xor,    5'd7,  5'd6,  5'd5,  12'd0,     1'b1);
        put(op_not,    5'd8,  5'd7,  5'd0,  12'd0,     1'b1);
        put(op_shftri, 5'd9,  5'd8,  5'd0,  12'd3,     1'b1);
        put(op_shftli, 5'd10, 5'd9,  5'd0,  12'd5,     1'b1);
        put(op_addi,   5'd11, 5'd0,  5'd0,  12'd7,     1'b1);
        put(op_shftr,  5'd12, 5'd10, 5'd11, 12'd0,     1'b1);
        put(op_shftl,  5'd13, 5'd12, 5'd11, 12'd0,     1'b1);
        put(op_mov,    5'd14, 5'd13, 5'd0,  12'd0,     1'b1);
        put(op_movl,   5'd14, 5'd0,  5'd0,  rnd_lit(), 1'b1);
        put(op_add,    5'd15, 5'd14, 5'd1,  12'd0,     1'b1);
        // store then load with the result used at once and two slots later
        put(op_addi,   5'd16, 5'd0,  5'd0,  12'h100,   1'b1);
        put(op_store,  5'd16, 5'd15, 5'd0,  12'd8,     1'b1);
        put(op_load,   5'd17, 5'd16, 5'd0,  12'd8,     1'b1);
        put(op_add,    5'd18, 5'd17, 5'd14, 12'd0,     1'b1);
        put(op_store,  5'd16, 5'd7,  5'd0,  12'hff0,   1'b1);
        put(op_load,   5'd19, 5'd16, 5'd0,  12'hff0,   1'b1);
        put(op_addi,   5'd1,  5'd0,  5'd0,  12'd1,     1'b1);
        // load still in EX/MEM while this one decodes costs one bubble
        put(op_xor,    5'd2,  5'd19, 5'd18, 12'd0,     1'b1);
        // r20 holds the reset pc as base for branch targets
        put(op_addi,   5'd20, 5'd0,  5'd0,  12'd1,     1'b1);
        put(op_shftli, 5'd20, 5'd20, 5'd0,  12'd13,    1'b1);
        // jump over three slots
        put(op_mov,    5'd21, 5'd20, 5'd0,  12'd0,     1'b1);
        put(op_movl,   5'd21, 5'd0,  5'd0,  pc_ahead(5), 1'b1);
        put(op_jump,   5'd21, 5'd0,  5'd0,  12'd0,     1'b1);
        put(op_addi,   5'd22, 5'd0,  5'd0,  12'd1,     1'b0);
        put(op_addi,   5'd23, 5'd0,  5'd0,  12'd1,     1'b0);
        put(op_addi,   5'd24, 5'd0,  5'd0,  12'd1,     1'b0);
        // taken brnz
        put(op_addi,   5'd25, 5'd0,  5'd0,  12'd5,     1'b1);
        put(op_mov,    5'd26, 5'd20, 5'd0,  12'd0,     1'b1);
        put(op_movl,   5'd26, 5'd0,  5'd0,  pc_ahead(5), 1'b1);
        put(op_brnz,   5'd26, 5'd25, 5'd0,  12'd0,     1'b1);
        put(op_addi,   5'd22, 5'd0,  5'd0,  12'd2,     1'b0);
        put(op_addi,   5'd23, 5'd0,  5'd0,  12'd2,     1'b0);
        put(op_addi,   5'd24, 5'd0,  5'd0,  12'd2,     1'b0);
        // brnz falls through once r25 is back to zero
        put(op_subi,   5'd25, 5'd0,  5'd0,  12'd5,     1'b1);
        put(op_brnz,   5'd26, 5'd25, 5'd0,  12'd0,     1'b1);
        put(op_addi,   5'd27, 5'd0,  5'd0,  12'd9,     1'b1);
        put(op_halt,   5'd0,  5'd0,  5'd0,  12'd0,     1'b1);
        // never issued past halt
        put(op_addi,   5'd28, 5'd0,  5'd0,  12'd1,     1'b0);
        put(op_addi,   5'd29, 5'd0,  5'd0,  12'd1,     1'b0);
    endtask

    // one word per cycle while reset is held
    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            #1;
            prog_we   = 1'b1;
            prog_addr = imem_addr_t'(i);
            prog_data = prog[i];
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;
    endtask

    task automatic check_writeback();
        reg_idx_t er;
        word_t    ev;
        assert (!shadow_reg[wb_reg]) else begin
            errors++;
            $display("%0t: register %0d written by an instruction that should not run",
                     $time, wb_reg);
        end
        assert (exp_reg.size() > 0) else begin
            errors++;
            $display("%0t: write-back to register %0d after all expected ones were seen",
                     $time, wb_reg);
        end
        if (exp_reg.size() > 0) begin
            er = exp_reg.pop_front();
            ev = exp_val.pop_front();
            assert (wb_reg == er) else begin
                errors++;
                $display("[FAIL] %0t wb_reg got %0d expected %0d", $time, wb_reg, er);
            end
            assert (wb_data === ev) else begin
                errors++;
                $display("[FAIL] %0t wb_data got %h expected %h", $time, wb_data, ev);
            end
        end
    endtask

    // write-back compared mid-cycle
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            check_writeback();
        end
    end

    initial begin
        void'($urandom(32'h4f87));
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        errors    = 0;
        prog_len  = 0;
        for (int i = 0; i < 32; i++) begin
            model_rf[i]   = '0;
            shadow_reg[i] = 1'b0;
        end
        build_program();
        prog_len = prog.size();
        load_program();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        wait (hlt === 1'b1);
        assert (exp_reg.size() == 0) else begin
            errors++;
            $display("%0t: core halted with %0d write-backs never seen", $time, exp_reg.size());
        end
        // room for a stray write-back after halt
        repeat (8) @(posedge clk);
        errors = errors + i_tinker_core.i_tinker_assert.fail_count;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog allows 40 cycles per instruction plus load and reset
    initial begin
        wait (prog_len > 0);
        repeat (prog_len * 40 + prog_len + 4) @(posedge clk);
        $display("timeout: core did not halt in time");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== tinker.f ====
+incdir+.
tinker_pkg.sv
tinker_ifs.sv
fetch_decode.sv
execute_stage.sv
mem_writeback.sv
tinker_core.sv
tinker_assert.sv
tinker_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the tinker core testbench with Verilator and run it
verilator --binary --assert --top-module tinker_tb -f tinker.f -o tinker_sim || exit 1
# keep running past assertion errors so the testbench prints its verdict
out=$(./obj_dir/tinker_sim +verilator+error+limit+1000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Result: PASSED" && exit 0 || exit 1
